/* rtl/az_acq_consts.svh */
`ifndef AZ_ACQ_CONSTS_SVH
`define AZ_ACQ_CONSTS_SVH

// widths
`define AZ_CNT_W      24        // precharge / aperture down-counters
`define AZ_MUX_W      4         // az input mux code
`define AZ_PAIR_W     28        // completed hi+lo pairs
`define AZ_ADDR_W     5         // apb byte address, reaches 0x14
`define AZ_DATA_W     32

// apb register map, byte addresses
`define AZ_REG_CTRL       5'h00   // bit 0 arm
`define AZ_REG_PRECHARGE  5'h04
`define AZ_REG_LOMUX      5'h08
`define AZ_REG_APERTURE   5'h0C
`define AZ_REG_STATUS     5'h10   // read only
`define AZ_REG_COUNT      5'h14   // read only

// register reset values
`define AZ_PRECHARGE_RST  24'd4
`define AZ_APERTURE_RST   24'd8
`define AZ_LOMUX_RST      4'h0

// az mux and precharge switch levels
`define AZMUX_PCOUT   4'h1      // hi path, via the precharge switch
`define SW_PC_BOOT    1'b0      // signal protected, boot drives pcout
`define SW_PC_SIGNAL  1'b1

`endif

/* rtl/az_acq_pkg.sv */
`include "az_acq_consts.svh"

package az_acq_pkg;

  // sequencer states, set-up state followed by its wait state
  typedef enum logic [4:0] {
    PARK,
    START,
    PC_BOOT,          // protect signal before touching the az mux
    PC_BOOT_WAIT,
    HI_SETTLE,        // az mux to pcout
    HI_SETTLE_WAIT,
    HI_SIGNAL,        // precharge switch to signal
    HI_SIGNAL_WAIT,
    HI_ACK,
    HI_MEAS,
    PC_REBOOT,
    PC_REBOOT_WAIT,
    LO_SETTLE,        // az mux to the lo reference
    LO_SETTLE_WAIT,
    LO_ACK,
    LO_MEAS
  } az_state_e;

  // adc stand-in
  typedef enum logic [1:0] {
    IDLE,
    ACK,
    INTEGRATE
  } adc_state_e;

  // register side configuration
  typedef struct packed {
    logic                  arm;
    logic [`AZ_MUX_W-1:0]  lo_mux;
    logic [`AZ_CNT_W-1:0]  precharge_cnt;
    logic [`AZ_CNT_W-1:0]  aperture_cnt;
  } acq_cfg_t;

  // sequencer status, displayed by the registers
  typedef struct packed {
    logic                  busy;
    logic                  sample_hi;   // 1 while the current sample is hi
    az_state_e             state;
    logic [`AZ_PAIR_W-1:0] pair_count;
  } acq_stat_t;

  // apb request bundle, prdata stays a plain port
  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`AZ_ADDR_W-1:0] paddr;
    logic [`AZ_DATA_W-1:0] pwdata;
  } apb_req_t;

endpackage

/* rtl/az_apb_regs.sv */
`include "az_acq_consts.svh"

module az_apb_regs import az_acq_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  apb_req_t              apb_req,
  input  acq_stat_t             stat,
  output logic [`AZ_DATA_W-1:0] prdata,
  output logic                  pslverr,
  output acq_cfg_t              cfg
);

  logic     acc;        // access phase
  logic     addr_ok;    // address is mapped
  logic     ro_addr;    // status or count
  logic     wr_en;
  acq_cfg_t cfg_q;

  assign acc = apb_req.psel && apb_req.penable;

  // address decode
  always_comb
  begin
    addr_ok = 1'b1;
    ro_addr = 1'b0;
    case (apb_req.paddr)
      `AZ_REG_CTRL, `AZ_REG_PRECHARGE, `AZ_REG_LOMUX, `AZ_REG_APERTURE: ;
      `AZ_REG_STATUS, `AZ_REG_COUNT:
        ro_addr = 1'b1;
      default:
        addr_ok = 1'b0;
    endcase
  end

  // error in the access cycle, register file untouched
  assign pslverr = acc && (!addr_ok || (apb_req.pwrite && ro_addr));
  assign wr_en   = acc && apb_req.pwrite && !pslverr;

  //////////////////////////////
  // writable registers

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cfg_q.arm           <= 1'b0;
      cfg_q.lo_mux        <= `AZ_LOMUX_RST;
      cfg_q.precharge_cnt <= `AZ_PRECHARGE_RST;
      cfg_q.aperture_cnt  <= `AZ_APERTURE_RST;
    end
    else if (wr_en)
    begin
      case (apb_req.paddr)
        `AZ_REG_CTRL:      cfg_q.arm           <= apb_req.pwdata[0];   // level held
        `AZ_REG_PRECHARGE: cfg_q.precharge_cnt <= apb_req.pwdata[`AZ_CNT_W-1:0];
        `AZ_REG_LOMUX:     cfg_q.lo_mux        <= apb_req.pwdata[`AZ_MUX_W-1:0];
        `AZ_REG_APERTURE:  cfg_q.aperture_cnt  <= apb_req.pwdata[`AZ_CNT_W-1:0];
        default: ;
      endcase
    end
  end

  assign cfg = cfg_q;

  //////////////////////////////
  // read mux, zero wait state

  always_comb
  begin
    prdata = '0;
    case (apb_req.paddr)
      `AZ_REG_CTRL:      prdata[0] = cfg_q.arm;
      `AZ_REG_PRECHARGE: prdata[`AZ_CNT_W-1:0] = cfg_q.precharge_cnt;
      `AZ_REG_LOMUX:     prdata[`AZ_MUX_W-1:0] = cfg_q.lo_mux;
      `AZ_REG_APERTURE:  prdata[`AZ_CNT_W-1:0] = cfg_q.aperture_cnt;
      `AZ_REG_STATUS:
      begin
        prdata[0]   = stat.busy;
        prdata[1]   = stat.sample_hi;
        prdata[6:2] = stat.state;     // az_state_e code
      end
      `AZ_REG_COUNT:     prdata[`AZ_PAIR_W-1:0] = stat.pair_count;
      default: ;                      // unmapped reads as zero
    endcase
  end

endmodule

/* rtl/az_sequencer.sv */
`include "az_acq_consts.svh"

module az_sequencer import az_acq_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  acq_cfg_t             cfg,
  input  logic                 adc_valid,
  output logic                 adc_trig,
  output logic                 sw_pc_ctl,
  output logic [`AZ_MUX_W-1:0] azmux,
  output acq_stat_t            stat
);

  az_state_e              state_q;
  logic [`AZ_CNT_W-1:0]   cnt_q;        // down-counter for the timed waits
  logic [1:0]             arm_sync;     // [1] older, [0] newer
  logic                   arm_rise;
  logic                   arm_fall;
  logic                   sample_hi_q;
  logic [`AZ_PAIR_W-1:0]  pair_q;

  assign arm_rise = arm_sync[0] && !arm_sync[1];
  assign arm_fall = !arm_sync[0] && arm_sync[1];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q     <= PARK;
      cnt_q       <= '0;
      arm_sync    <= 2'b00;
      adc_trig    <= 1'b0;
      sw_pc_ctl   <= `SW_PC_BOOT;
      azmux       <= `AZ_LOMUX_RST;
      sample_hi_q <= 1'b0;
      pair_q      <= '0;
    end
    else
    begin
      cnt_q    <= cnt_q - 1'b1;                 // free running, reloaded per phase
      arm_sync <= {arm_sync[0], cfg.arm};

      case (state_q)
        PARK: ;                                 // held until an arm rise
        START:
          state_q <= PC_BOOT;

        //////////////////////////////
        // protect the signal from az switch charge injection
        PC_BOOT:
        begin
          sw_pc_ctl <= `SW_PC_BOOT;
          cnt_q     <= cfg.precharge_cnt;
          state_q   <= PC_BOOT_WAIT;
        end
        PC_BOOT_WAIT:
          if (cnt_q == '0) state_q <= HI_SETTLE;

        //////////////////////////////
        // hi sample
        HI_SETTLE:
        begin
          azmux   <= `AZMUX_PCOUT;              // signal still behind boot
          cnt_q   <= cfg.precharge_cnt;
          state_q <= HI_SETTLE_WAIT;
        end
        HI_SETTLE_WAIT:
          if (cnt_q == '0) state_q <= HI_SIGNAL;
        HI_SIGNAL:
        begin
          sw_pc_ctl <= `SW_PC_SIGNAL;           // let the sig/boot offset settle
          cnt_q     <= cfg.precharge_cnt;
          state_q   <= HI_SIGNAL_WAIT;
        end
        HI_SIGNAL_WAIT:
          if (cnt_q == '0)
          begin
            adc_trig <= 1'b1;
            state_q  <= HI_ACK;
          end
        HI_ACK:
          if (!adc_valid)                       // adc took the trigger
          begin
            adc_trig    <= 1'b0;
            sample_hi_q <= 1'b1;
            state_q     <= HI_MEAS;
          end
        HI_MEAS:
          if (adc_valid) state_q <= PC_REBOOT;

        //////////////////////////////
        // lo sample
        PC_REBOOT:
        begin
          sw_pc_ctl <= `SW_PC_BOOT;
          cnt_q     <= cfg.precharge_cnt;
          state_q   <= PC_REBOOT_WAIT;
        end
        PC_REBOOT_WAIT:
          if (cnt_q == '0) state_q <= LO_SETTLE;
        LO_SETTLE:
        begin
          azmux   <= cfg.lo_mux;                // zero reference
          cnt_q   <= cfg.precharge_cnt;
          state_q <= LO_SETTLE_WAIT;
        end
        LO_SETTLE_WAIT:
          if (cnt_q == '0)
          begin
            adc_trig <= 1'b1;
            state_q  <= LO_ACK;
          end
        LO_ACK:
          if (!adc_valid)
          begin
            adc_trig    <= 1'b0;
            sample_hi_q <= 1'b0;
            state_q     <= LO_MEAS;
          end
        LO_MEAS:
          if (adc_valid)
          begin
            pair_q  <= pair_q + 1'b1;           // hi+lo pair done
            state_q <= HI_SETTLE;               // loop, no second boot phase
          end
        default:
          state_q <= PARK;
      endcase

      // arm edges win over the case above
      if (arm_rise)
      begin
        state_q  <= START;
        adc_trig <= 1'b0;
      end
      else if (arm_fall)
      begin
        state_q  <= PARK;
        adc_trig <= 1'b0;
      end
    end
  end

  assign stat = '{busy:       (state_q != PARK),
                  sample_hi:  sample_hi_q,
                  state:      state_q,
                  pair_count: pair_q};

  // a trigger only ever samples the hi path or the selected lo reference
  a_trig_path: assert property (@(posedge clk) disable iff (!rst_n)
    adc_trig |-> (((azmux == `AZMUX_PCOUT) && (sw_pc_ctl == `SW_PC_SIGNAL))
                  || (azmux == cfg.lo_mux)));

  // parked sequencer only wakes two cycles after the arm register rises
  a_park_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ((state_q == PARK) && !($past(cfg.arm) && !$past(cfg.arm, 2))) |=> (state_q == PARK));

endmodule

/* rtl/adc_aperture_ctl.sv */
`include "az_acq_consts.svh"

module adc_aperture_ctl import az_acq_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  acq_cfg_t cfg,
  input  logic     adc_trig,
  output logic     adc_valid
);

  adc_state_e           state_q;
  logic [`AZ_CNT_W-1:0] cnt_q;    // aperture down-counter

  //////////////////////////////
  // integrating adc stand-in

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q   <= IDLE;
      cnt_q     <= '0;
      adc_valid <= 1'b1;          // nothing pending out of reset
    end
    else
    begin
      case (state_q)
        IDLE:
          if (adc_trig)
          begin
            adc_valid <= 1'b0;    // acknowledge
            state_q   <= ACK;
          end
        ACK:
        begin
          // aperture is sampled once per conversion
          cnt_q   <= cfg.aperture_cnt;
          state_q <= INTEGRATE;
        end
        INTEGRATE:
        begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == '0)        // aperture_cnt+1 cycles spent here
          begin
            adc_valid <= 1'b1;    // held until the next trigger
            state_q   <= IDLE;
          end
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

endmodule

/* rtl/az_acq_top.sv */
`include "az_acq_consts.svh"

module az_acq_top import az_acq_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [`AZ_ADDR_W-1:0] paddr,
  input  logic [`AZ_DATA_W-1:0] pwdata,
  output logic [`AZ_DATA_W-1:0] prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic [`AZ_MUX_W-1:0]  azmux,
  output logic                  sw_pc_ctl,
  output logic [1:0]            monitor
);

  apb_req_t  apb_req;
  acq_cfg_t  cfg;
  acq_stat_t stat;
  logic      adc_trig;
  logic      adc_valid;

  assign apb_req = '{psel: psel, penable: penable, pwrite: pwrite,
                     paddr: paddr, pwdata: pwdata};
  assign pready  = 1'b1;                          // no wait states

  az_apb_regs regs_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .apb_req (apb_req),
    .stat    (stat),
    .prdata  (prdata),
    .pslverr (pslverr),
    .cfg     (cfg)
  );

  az_sequencer seq_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .adc_valid (adc_valid),
    .adc_trig  (adc_trig),
    .sw_pc_ctl (sw_pc_ctl),
    .azmux     (azmux),
    .stat      (stat)
  );

  adc_aperture_ctl adc_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .adc_trig  (adc_trig),
    .adc_valid (adc_valid)
  );

  assign monitor[0] = adc_trig;
  assign monitor[1] = (azmux == `AZMUX_PCOUT);    // taking a hi sample

endmodule

/* testbench/tb_az_acq_top.sv */
`include "az_acq_consts.svh"

module tb_az_acq_top import az_acq_pkg::*; ();

  logic                  clk;
  logic                  rst_n;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [`AZ_ADDR_W-1:0] paddr;
  logic [`AZ_DATA_W-1:0] pwdata;
  logic [`AZ_DATA_W-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic [`AZ_MUX_W-1:0]  azmux;
  logic                  sw_pc_ctl;
  logic [1:0]            monitor;    // [0] adc_trig, [1] hi path selected

  acq_cfg_t    shadow;               // register model
  int          exp_pairs;            // completed lo triggers
  bit          last_lo;              // previous trigger was a lo sample
  logic [31:0] lcg_state;
  int          errors;
  int          timeouts;

  az_acq_top dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .azmux     (azmux),
    .sw_pc_ctl (sw_pc_ctl),
    .monitor   (monitor)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // random numbers and model

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_range(input logic [31:0] lo, input logic [31:0] hi);
    logic [31:0] r;
    r = lcg_next();
    return lo + (r[31:8] % (hi - lo + 32'd1));    // upper bits, low ones are weak
  endfunction

  function automatic logic [31:0] model_read(input logic [`AZ_ADDR_W-1:0] addr);
    logic [31:0] v;
    v = '0;
    case (addr)
      `AZ_REG_CTRL:      v[0] = shadow.arm;
      `AZ_REG_PRECHARGE: v[`AZ_CNT_W-1:0] = shadow.precharge_cnt;
      `AZ_REG_LOMUX:     v[`AZ_MUX_W-1:0] = shadow.lo_mux;
      `AZ_REG_APERTURE:  v[`AZ_CNT_W-1:0] = shadow.aperture_cnt;
      `AZ_REG_COUNT:     v = 32'(exp_pairs);
      default: ;
    endcase
    return v;
  endfunction

  task automatic model_write(input logic [`AZ_ADDR_W-1:0] addr, input logic [31:0] data);
    case (addr)
      `AZ_REG_CTRL:      shadow.arm = data[0];
      `AZ_REG_PRECHARGE: shadow.precharge_cnt = data[`AZ_CNT_W-1:0];
      `AZ_REG_LOMUX:     shadow.lo_mux = data[`AZ_MUX_W-1:0];
      `AZ_REG_APERTURE:  shadow.aperture_cnt = data[`AZ_CNT_W-1:0];
      default: ;
    endcase
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  //////////////////////////////
  // apb driver

  task automatic apb_access(input logic write, input logic [`AZ_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    int waited;
    @(negedge clk);                    // setup phase
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);                    // access phase
    penable = 1'b1;
    #1;
    waited = 0;
    while (!pready && waited < 16)
    begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!pready)
    begin
      $display("apb access to %h got no pready within %0d cycles", addr, waited);
      timeouts++;
    end
    rdata = prdata;                    // comb read, stable mid cycle
    err   = pslverr;
    @(negedge clk);                    // access taken at the posedge before
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input string name, input logic [`AZ_ADDR_W-1:0] addr,
                           input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, addr, data, rd, err);
    check_value({name, " pslverr"}, 32'd0, 32'(err));
    model_write(addr, data);
  endtask

  task automatic reg_read(input string name, input logic [`AZ_ADDR_W-1:0] addr,
                          output logic [31:0] data);
    logic err;
    apb_access(1'b0, addr, '0, data, err);
    check_value({name, " pslverr"}, 32'd0, 32'(err));
  endtask

  task automatic read_check(input string name, input logic [`AZ_ADDR_W-1:0] addr);
    logic [31:0] rd;
    reg_read(name, addr, rd);
    check_value(name, model_read(addr), rd);
  endtask

  task automatic read_all(input string name);
    read_check({name, " ctrl"}, `AZ_REG_CTRL);
    read_check({name, " precharge"}, `AZ_REG_PRECHARGE);
    read_check({name, " lomux"}, `AZ_REG_LOMUX);
    read_check({name, " aperture"}, `AZ_REG_APERTURE);
  endtask

  //////////////////////////////
  // trigger monitor

  // waits for the next monitor[0] rise and checks the sample path it sees
  task automatic wait_trigger(input string name, input bit hi);
    int   cycles;
    logic prev;
    logic found;
    prev   = monitor[0];
    found  = 1'b0;
    cycles = 0;
    while (!found && cycles < 500)
    begin
      @(negedge clk);
      found = !prev && monitor[0];
      prev  = monitor[0];
      cycles++;
    end
    if (!found)
    begin
      $display("%s: no adc trigger seen within %0d cycles", name, cycles);
      timeouts++;
    end
    else
    begin
      check_value({name, " hi path"}, 32'(hi), 32'(monitor[1]));
      if (hi)
      begin
        check_value({name, " switch"}, 32'(`SW_PC_SIGNAL), 32'(sw_pc_ctl));
        if (last_lo)
          exp_pairs++;                 // the lo sample before this one completed
      end
      else
      begin
        check_value({name, " switch"}, 32'(`SW_PC_BOOT), 32'(sw_pc_ctl));
        check_value({name, " lo mux"}, 32'(shadow.lo_mux), 32'(azmux));
      end
      last_lo = !hi;
    end
  endtask

  // new random settings while parked, then arm and follow eight samples
  task automatic arm_and_follow(input string name);
    reg_write({name, " precharge"}, `AZ_REG_PRECHARGE, rand_range(32'd2, 32'd9));
    reg_write({name, " aperture"}, `AZ_REG_APERTURE, rand_range(32'd3, 32'd20));
    reg_write({name, " lomux"}, `AZ_REG_LOMUX, rand_range(32'd2, 32'd15));  // never pcout
    reg_write({name, " arm"}, `AZ_REG_CTRL, 32'd1);
    for (int i = 0; i < 8; i++)
      wait_trigger(name, (i % 2) == 0);    // hi first, then alternating
  endtask

  //////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] rd;
    logic        err;
    int          n;
    int          high_cycles;

    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    lcg_state = 32'h3e7a;
    errors    = 0;
    timeouts  = 0;
    exp_pairs = 0;
    last_lo   = 1'b0;
    shadow    = '{arm: 1'b0, lo_mux: `AZ_LOMUX_RST,
                  precharge_cnt: `AZ_PRECHARGE_RST, aperture_cnt: `AZ_APERTURE_RST};
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // reset state and register readback
    check_value("reset monitor", 32'd0, 32'(monitor));
    check_value("reset switch", 32'(`SW_PC_BOOT), 32'(sw_pc_ctl));
    check_value("reset azmux", 32'(`AZ_LOMUX_RST), 32'(azmux));
    check_value("reset pslverr", 32'd0, 32'(pslverr));
    read_all("reset");
    reg_read("reset status", `AZ_REG_STATUS, rd);
    check_value("reset status", {25'd0, 5'(PARK), 1'b0, 1'b0}, rd);
    read_check("reset count", `AZ_REG_COUNT);
    repeat (4)
    begin
      reg_write("rand precharge", `AZ_REG_PRECHARGE, lcg_next());
      reg_write("rand lomux", `AZ_REG_LOMUX, lcg_next());
      reg_write("rand aperture", `AZ_REG_APERTURE, lcg_next());
      reg_write("rand ctrl", `AZ_REG_CTRL, lcg_next() & ~32'h1);   // stay parked
      read_all("rand readback");
    end

    // unmapped read and read-only write
    apb_access(1'b0, 5'h18, '0, rd, err);
    check_value("unmapped read pslverr", 32'd1, 32'(err));
    apb_access(1'b1, `AZ_REG_STATUS, lcg_next(), rd, err);
    check_value("status write pslverr", 32'd1, 32'(err));
    read_all("after bad access");

    // hi / lo alternation
    arm_and_follow("first arm");

    // pair counter
    wait_trigger("count hi", 1'b1);      // closes the pair of the last lo
    n = int'(rand_range(32'd3, 32'd6));
    repeat (n)
    begin
      wait_trigger("count lo", 1'b0);
      wait_trigger("count hi", 1'b1);
    end
    reg_read("count status", `AZ_REG_STATUS, rd);
    check_value("count busy", 32'd1, 32'(rd[0]));
    check_value("count sample_hi", 32'd1, 32'(rd[1]));
    read_check("count value", `AZ_REG_COUNT);

    // park, then re-arm
    read_check("park count before", `AZ_REG_COUNT);
    reg_write("park", `AZ_REG_CTRL, 32'd0);
    last_lo     = 1'b0;
    high_cycles = 0;
    repeat (200)
    begin
      @(negedge clk);
      if (monitor[0])
        high_cycles++;
    end
    if (high_cycles != 0)
    begin
      $display("adc trigger was high for %0d cycles while parked", high_cycles);
      errors++;
    end
    read_check("park count after", `AZ_REG_COUNT);
    reg_read("park status", `AZ_REG_STATUS, rd);
    check_value("park busy", 32'd0, 32'(rd[0]));
    check_value("park state", 32'(PARK), 32'(rd[6:2]));
    arm_and_follow("re-arm");
    wait_trigger("re-arm hi", 1'b1);
    read_check("re-arm count", `AZ_REG_COUNT);

    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

/* flist.f */
+incdir+rtl
rtl/az_acq_pkg.sv
rtl/az_apb_regs.sv
rtl/az_sequencer.sv
rtl/adc_aperture_ctl.sv
rtl/az_acq_top.sv
testbench/tb_az_acq_top.sv

/* run_sim.sh */
#!/bin/sh
# verilator build and run of the az acquisition testbench

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_az_acq_top -f flist.f -o tb_az_acq_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_az_acq_top > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

# a failed check or a timeout ends the log with the fail message
if grep -q "sim failed" "$log"; then
  exit 1
fi
exit 0
